// File: sim.f
+incdir+verification
hw/positPkg.sv
hw/positDecode.sv
hw/positDiv.sv
hw/positEncode.sv
hw/positDivider.sv
verification/positDividerTb.sv

// File: run.sh
#!/bin/sh
# build and run the posit divider testbench, exit status is the verdict
cd "$(dirname "$0")" &&
    verilator --binary --timing -Wno-fatal -f sim.f --top-module positDividerTb -Mdir obj_dir &&
    ./obj_dir/VpositDividerTb ||
    { echo "simulation did not pass"; exit 1; }

// File: verification/positDivModel.svh
`ifndef POSIT_DIV_MODEL_SVH
`define POSIT_DIV_MODEL_SVH
// posit16 reference model for the divider testbench
// unpacks posits and forms the correctly rounded quotient with integers

// sign, scale k*2+e and significand 1.f with 14 fraction bits
function automatic void unpackPosit(input logic [15:0] p, output logic neg,
                                    output int scale, output longint sig);
    logic [15:0] mag;
    int run;
    int idx;
    int k;
    int e;
    neg = p[15];
    mag = p[15] ? -p : p;
    run = 1;
    while (run < 15 && mag[14-run] == mag[14]) begin
        run++;
    end
    k   = mag[14] ? run - 1 : -run;
    idx = 13 - run;                 // first bit past the terminator
    e   = 0;
    if (idx >= 0) begin
        e = mag[idx];
        idx--;
    end
    sig = 1;                        // hidden one
    for (int i = 0; i < 14; i++) begin
        sig = sig << 1;
        if (idx >= 0) begin
            sig = sig | mag[idx];
            idx--;
        end
    end
    scale = 2 * k + e;
endfunction

// quotient a / b, bit string rounded to nearest even, clamped to min/maxpos
function automatic logic [15:0] modelQuotient(input logic [15:0] a, input logic [15:0] b);
    logic        negA;
    logic        negB;
    int          scaleA;
    int          scaleB;
    int          s;
    int          k;
    int          len;
    int          runLen;
    longint      sigA;
    longint      sigB;
    longint      q;
    longint      frac;
    longint      bits;
    longint      rest;
    logic        sticky;
    logic        roundBit;
    logic [15:0] body;
    if (a == 16'h8000 || b == 16'h8000 || b == 16'h0000) begin
        return 16'h8000;
    end
    if (a == 16'h0000) begin
        return 16'h0000;
    end
    unpackPosit(a, negA, scaleA, sigA);
    unpackPosit(b, negB, scaleB, sigB);
    q      = (sigA << 30) / sigB;               // ratio in (2^29, 2^31)
    sticky = ((sigA << 30) % sigB) != 0;
    s      = scaleA - scaleB;
    if (q >= (64'sd1 << 30)) begin
        frac = q - (64'sd1 << 30);              // 30 fraction bits
    end else begin
        frac = (q << 1) - (64'sd1 << 30);
        s    = s - 1;
    end
    k = s >>> 1;                                // floor(s / 2)
    if (k > 13) begin
        body = 16'h7fff;
    end else if (k < -14) begin
        body = 16'h0001;
    end else begin
        runLen = (k >= 0) ? k + 1 : -k;
        bits   = 0;
        len    = 0;
        for (int i = 0; i < runLen; i++) begin
            bits = (bits << 1) | ((k >= 0) ? 1 : 0);
            len++;
        end
        bits = (bits << 1) | ((k >= 0) ? 0 : 1);    // terminator
        bits = (bits << 1) | (s - 2 * k);           // es bit
        bits = (bits << 30) | frac;
        len  = len + 32;
        body     = 16'(bits >> (len - 15));
        rest     = bits & ((64'sd1 << (len - 15)) - 1);
        roundBit = rest[len-16];
        sticky   = sticky | ((rest & ((64'sd1 << (len - 16)) - 1)) != 0);
        if (roundBit && (body[0] || sticky)) begin
            body = body + 1;
        end
        if (body == 16'h0000) begin
            body = 16'h0001;                        // never to zero
        end
        if (body[15]) begin
            body = 16'h7fff;                        // never to NaR
        end
    end
    return (negA ^ negB) ? -body : body;
endfunction

`endif

// File: verification/positDividerTb.sv
`timescale 1ns/100ps
`default_nettype none
// posit divider testbench
// directed and random posit16 pairs with idle gaps, every quotient is
// checked against the integer model, outValid against the two cycle latency

module positDividerTb;

    localparam positPkg::positFormat fmt = positPkg::posit16;
    localparam int unsigned N   = positPkg::positWidth(fmt);
    localparam int numRandom    = 400;
    localparam int numIdentity  = 20;
    localparam int numDirected  = 12;
    localparam int resetCycles  = 8;
    // each vector may bring one gap, plus reset and drain
    localparam int maxCycles =
        resetCycles + 2 * (numRandom + 3 * numIdentity + numDirected) + 20;

    logic         clk;
    logic         reset;
    logic         inValid;
    logic [N-1:0] dividend;
    logic [N-1:0] divisor;
    logic [N-1:0] quotient;
    logic         outValid;

    logic [31:0]  lcgState = 32'hab2c_1318;
    logic [N-1:0] expectQ[$];           // results in flight, oldest first
    logic [1:0]   validHist = '0;       // inValid of the last two cycles
    int           cycleCount = 0;

    `include "positDivModel.svh"

    positDivider #(.pFormat(fmt)) DUT (
        .clk      (clk),
        .reset    (reset),
        .inValid  (inValid),
        .dividend (dividend),
        .divisor  (divisor),
        .quotient (quotient),
        .outValid (outValid)
    );

    always #50 clk = ~clk;   // 100 ns period

    ///////////////////////////////////////////////////////////////////////
    // checks
    ///////////////////////////////////////////////////////////////////////

    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkQuotient(input logic [N-1:0] got, input logic [N-1:0] expected);
        if (got !== expected) begin
            stopOnError($sformatf("[ERROR] quotient got %h expected %h", got, expected));
        end
    endtask

    task automatic checkValid(input logic got, input logic expected);
        if (got !== expected) begin
            stopOnError($sformatf("[ERROR] outValid got %h expected %h", got, expected));
        end
    endtask

    // outputs of the edge just passed, 1 ns after it
    task automatic sampleOutputs();
        validHist = {validHist[0], inValid};
        checkValid(outValid, validHist[1]);
        if (outValid) begin
            if (expectQ.size() == 0) begin
                stopOnError("a quotient came out with no pair in flight");
            end else begin
                checkQuotient(quotient, expectQ.pop_front());
            end
        end
    endtask

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > maxCycles) begin
            stopOnError("the run went past its cycle limit without finishing");
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // stimulus
    ///////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // any posit except zero and NaR
    function automatic logic [N-1:0] randomOperand();
        logic [31:0] r;
        r = nextRandom();
        if (r[31:16] == 16'h0000 || r[31:16] == 16'h8000) begin
            return r[31:16] ^ 16'h0001;
        end
        return r[31:16];
    endfunction

    task automatic driveCycle(input logic v, input logic [N-1:0] a,
                              input logic [N-1:0] b, input logic [N-1:0] expected);
        @(posedge clk);
        #1;
        sampleOutputs();
        inValid  = v;
        dividend = a;
        divisor  = b;
        if (v) begin
            expectQ.push_back(expected);
        end
    endtask

    task automatic sendPair(input logic [N-1:0] a, input logic [N-1:0] b,
                            input logic [N-1:0] expected);
        driveCycle(1'b1, a, b, expected);
    endtask

    task automatic idleCycle();
        driveCycle(1'b0, '0, '0, '0);
    endtask

    initial begin
        logic [N-1:0] x;
        logic [N-1:0] y;
        logic [31:0]  r;
        clk      = 1'b0;
        reset    = 1'b1;
        inValid  = 1'b0;
        dividend = '0;
        divisor  = '0;
        repeat (resetCycles) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (3) idleCycle();   // outValid stays low before any pair

        // NaR in, zero divisor
        sendPair(16'h8000, 16'h4000, 16'h8000);
        sendPair(16'h4000, 16'h8000, 16'h8000);
        sendPair(16'h8000, 16'h0000, 16'h8000);
        sendPair(16'h3a5c, 16'h0000, 16'h8000);
        sendPair(16'h0000, 16'h0000, 16'h8000);
        // zero dividend
        sendPair(16'h0000, 16'h4000, 16'h0000);
        sendPair(16'h0000, 16'hc4a1, 16'h0000);
        sendPair(16'h0000, 16'h0001, 16'h0000);
        // saturation at maxpos and minpos, both signs
        sendPair(16'h7fff, 16'h0001, 16'h7fff);
        sendPair(16'h0001, 16'h7fff, 16'h0001);
        sendPair(16'h8001, 16'h0001, 16'h8001);
        sendPair(16'hffff, 16'h7fff, 16'hffff);

        // x / x is one, x / one is x, a negated operand negates the result
        for (int i = 0; i < numIdentity; i++) begin
            x = randomOperand();
            y = randomOperand();
            sendPair(x, x, 16'h4000);
            sendPair(x, 16'h4000, x);
            if (i % 2 == 0) begin
                sendPair(-x, y, -modelQuotient(x, y));
            end else begin
                sendPair(x, -y, -modelQuotient(x, y));
            end
        end

        // random pairs, back to back or after a one cycle gap
        for (int i = 0; i < numRandom; i++) begin
            r = nextRandom();
            if (r[31:30] == 2'b00) begin
                idleCycle();
            end
            x = randomOperand();
            y = randomOperand();
            sendPair(x, y, modelQuotient(x, y));
        end

        repeat (3) idleCycle();   // drain both stages
        if (expectQ.size() != 0) begin
            stopOnError("the pipeline went idle with results still missing");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: hw/positDivider.sv
`timescale 1ns/100ps
`default_nettype none
// pipelined posit divider
// two decoders feed the divide stage, the encode stage follows,
// a quotient leaves two cycles after its operands

module positDivider #(
    parameter positPkg::positFormat pFormat = positPkg::posit16,
    localparam int unsigned N = positPkg::positWidth(pFormat)
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         inValid,
    input  logic [N-1:0] dividend,
    input  logic [N-1:0] divisor,
    output logic [N-1:0] quotient,
    output logic         outValid
);

    positPkg::decodedPosit   numFields;   // decoded dividend
    positPkg::decodedPosit   denFields;   // decoded divisor
    positPkg::quotientFields divFields;   // divide stage register

    positDecode #(.pFormat(pFormat)) numDecode (
        .posit  (dividend),
        .fields (numFields)
    );

    positDecode #(.pFormat(pFormat)) denDecode (
        .posit  (divisor),
        .fields (denFields)
    );

    // cycle 1
    positDiv #(.pFormat(pFormat)) divStage (
        .clk         (clk),
        .reset       (reset),
        .inValid     (inValid),
        .numerator   (numFields),
        .denominator (denFields),
        .result      (divFields)
    );

    // cycle 2
    positEncode #(.pFormat(pFormat)) encStage (
        .clk      (clk),
        .reset    (reset),
        .fields   (divFields),
        .quotient (quotient),
        .outValid (outValid)
    );

endmodule

`default_nettype wire

// File: hw/positEncode.sv
`timescale 1ns/100ps
`default_nettype none
// posit encode stage
// packs regime, exponent and fraction, rounds to nearest even with
// saturation at minpos and maxpos, applies sign and special patterns

module positEncode #(
    parameter positPkg::positFormat pFormat = positPkg::posit16,
    localparam int unsigned N  = positPkg::positWidth(pFormat),
    localparam int unsigned ES = positPkg::expBits(pFormat)
) (
    input  logic                    clk,
    input  logic                    reset,
    input  positPkg::quotientFields fields,
    output logic [N-1:0]            quotient,
    output logic                    outValid
);

    localparam int unsigned SB = positPkg::scaleBits;
    localparam int unsigned RB = positPkg::runBits;
    localparam int unsigned FW = 2 * N - 1;        // fraction incl sticky
    localparam int unsigned TW = N + ES + FW;      // room to shift the run in

    logic           scaleNeg;     // negative scale, regime of zeros
    logic           saturate;
    logic [RB-1:0]  shiftAmt;
    logic [FW-1:0]  fracBits;
    logic [TW-1:0]  unshifted;
    logic [TW-1:0]  fillMask;
    logic [TW-1:0]  assembled;
    logic [N-2:0]   kept;
    logic           guardBit;
    logic           roundBit;
    logic           stickyBit;
    logic           roundUp;
    logic [N-2:0]   body;
    logic [N-1:0]   magnitude;
    logic [N-1:0]   encoded;

    assign scaleNeg = fields.totalScale[SB-1];
    assign fracBits = fields.mantissa[FW-1:0];   // hidden one dropped

    // run of N-1 or more leaves no room, pin to maxpos or minpos
    assign saturate = (fields.regimeRun >= RB'(N - 1));
    assign shiftAmt = saturate ? RB'(N - 1) : fields.regimeRun;

    ///////////////////////////////////////////////////////////////////////
    // field assembly
    ///////////////////////////////////////////////////////////////////////

    // terminator on top, then es bits, then fraction, then shift room
    assign unshifted = (TW'(scaleNeg) << (TW - 1))
                     | (TW'(fields.exponent) << (TW - 1 - ES))
                     | (TW'(fracBits) << (N - 1));

    // positive regimes shift in ones, negative ones shift in zeros
    assign fillMask  = scaleNeg ? '0 : ~({TW{1'b1}} >> shiftAmt);
    assign assembled = (unshifted >> shiftAmt) | fillMask;

    ///////////////////////////////////////////////////////////////////////
    // round to nearest even
    ///////////////////////////////////////////////////////////////////////

    assign kept      = assembled[TW-1 -: N-1];
    assign guardBit  = assembled[TW-N+1];        // last kept bit, breaks ties
    assign roundBit  = assembled[TW-N];          // first dropped bit
    assign stickyBit = |assembled[TW-N-1:0];
    assign roundUp   = roundBit & (guardBit | stickyBit);

    always_comb begin
        if (saturate) begin
            body = scaleNeg ? {{(N-2){1'b0}}, 1'b1} : '1;   // minpos or maxpos
        end else begin
            body = kept + (N-1)'(roundUp);   // never carries into the sign
        end
    end

    assign magnitude = {1'b0, body};

    always_comb begin
        if (fields.nar) begin
            encoded = {1'b1, {(N-1){1'b0}}};
        end else if (fields.zero) begin
            encoded = '0;
        end else if (fields.sign) begin
            encoded = -magnitude;   // negative posits are two's complement
        end else begin
            encoded = magnitude;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            quotient <= '0;
            outValid <= 1'b0;
        end else begin
            quotient <= encoded;
            outValid <= fields.valid;
        end
    end

endmodule

`default_nettype wire

// File: hw/positDiv.sv
`timescale 1ns/100ps
`default_nettype none
// posit divide stage
// divides the mantissas, subtracts the scales, normalises the quotient and
// splits the scale into regime run and exponent, one register stage

module positDiv #(
    parameter positPkg::positFormat pFormat = positPkg::posit16,
    localparam int unsigned N  = positPkg::positWidth(pFormat),
    localparam int unsigned ES = positPkg::expBits(pFormat),
    localparam int unsigned RS = $clog2(N)
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    inValid,
    input  positPkg::decodedPosit   numerator,
    input  positPkg::decodedPosit   denominator,
    output positPkg::quotientFields result
);

    localparam int unsigned SB = positPkg::scaleBits;
    localparam int unsigned RB = positPkg::runBits;
    localparam int unsigned EB = positPkg::maxEs;
    localparam int unsigned MB = 2 * positPkg::maxN;
    localparam int unsigned QB = 2 * N + 1;               // quotient needs 2N+1 bits
    localparam logic [EB-1:0] expMask = EB'((1 << ES) - 1);

    logic [N-1:0]           mantA;
    logic [N-1:0]           mantB;
    logic [3*N-1:0]         dividendWide;
    logic [3*N-1:0]         divisorWide;
    logic [QB-1:0]          rawQuot;
    logic [N-1:0]           remainder;
    logic [2*N-1:0]         normMant;
    logic                   underflow;    // quotient below one
    logic signed [RS+1:0]   regimeDiff;
    logic signed [SB-1:0]   scaleRegime;
    logic signed [SB-1:0]   expA;
    logic signed [SB-1:0]   expB;
    logic signed [SB-1:0]   scale;
    logic [SB-1:0]          scaleMag;
    logic [SB-1:0]          regimeMag;
    logic [RB-1:0]          runLength;
    positPkg::quotientFields stageNext;

    ///////////////////////////////////////////////////////////////////////
    // mantissa division
    ///////////////////////////////////////////////////////////////////////

    assign mantA        = numerator.mantissa[N-1:0];
    assign mantB        = denominator.mantissa[N-1:0];
    assign dividendWide = {mantA, {(2*N){1'b0}}};   // widen by 2N bits
    assign divisorWide  = {{(2*N){1'b0}}, mantB};
    assign rawQuot      = QB'(dividendWide / divisorWide);
    assign remainder    = N'(dividendWide % divisorWide);

    // ratio lies in (0.5, 2), leading one sits at bit 2N or 2N-1
    always_comb begin
        if (rawQuot[2*N]) begin
            normMant  = {rawQuot[2*N:2], |{rawQuot[1:0], remainder}};
            underflow = 1'b0;
        end else begin
            // one position lower, same as a left shift by one
            normMant  = {rawQuot[2*N-1:1], |{rawQuot[0], remainder}};
            underflow = 1'b1;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // scale, regime run and exponent
    ///////////////////////////////////////////////////////////////////////

    assign regimeDiff  = $signed(numerator.regime[RS:0]) - $signed(denominator.regime[RS:0]);
    assign scaleRegime = {{(SB-RS-2){regimeDiff[RS+1]}}, regimeDiff};
    assign expA        = {{(SB-EB){1'b0}}, numerator.exponent};
    assign expB        = {{(SB-EB){1'b0}}, denominator.exponent};
    assign scale       = (scaleRegime <<< ES) + expA - expB
                         - $signed({{(SB-1){1'b0}}, underflow});

    assign scaleMag  = scale[SB-1] ? -scale : scale;
    assign regimeMag = scaleMag >> ES;

    always_comb begin
        if (!scale[SB-1]) begin
            runLength = RB'(regimeMag) + 1'b1;   // k + 1 ones
        end else begin
            // ceiling of |scale| / 2^es zeros
            runLength = RB'(regimeMag) + RB'(|(scaleMag[EB-1:0] & expMask));
        end
    end

    always_comb begin
        stageNext            = '0;
        stageNext.valid      = inValid;
        stageNext.nar        = numerator.nar | denominator.nar | denominator.zero;
        stageNext.zero       = !stageNext.nar && numerator.zero;
        stageNext.sign       = numerator.sign ^ denominator.sign;
        stageNext.totalScale = scale;
        stageNext.regimeRun  = runLength;
        stageNext.exponent   = scale[EB-1:0] & expMask;   // low bits, floor mod 2^es
        stageNext.mantissa   = MB'(normMant);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
        end else begin
            result <= stageNext;
        end
    end

endmodule

`default_nettype wire

// File: hw/positDecode.sv
`timescale 1ns/100ps
`default_nettype none
// posit field decoder
// splits one posit into sign, regime count, exponent and a left aligned
// mantissa with the hidden one, flags NaR and zero, purely combinational

module positDecode #(
    parameter positPkg::positFormat pFormat = positPkg::posit16,
    localparam int unsigned N  = positPkg::positWidth(pFormat),
    localparam int unsigned ES = positPkg::expBits(pFormat)
) (
    input  logic [N-1:0]          posit,
    output positPkg::decodedPosit fields
);

    localparam int unsigned EB = positPkg::maxEs;
    localparam int unsigned KB = positPkg::maxRs + 1;   // regime count width
    localparam int unsigned MB = positPkg::maxN;

    logic [N-1:0]          magnitude;   // two's complement of negative posits
    logic [N-2:0]          body;        // everything after the sign
    logic [N-2:0]          tail;        // regime and terminator stripped
    logic [N-2:0]          fracBits;    // fraction, left aligned
    logic [EB-1:0]         expWide;
    logic [KB-1:0]         runLength;
    logic signed [KB-1:0]  regimeK;

    assign magnitude = posit[N-1] ? -posit : posit;
    assign body      = magnitude[N-2:0];

    ///////////////////////////////////////////////////////////////////////
    // regime run
    ///////////////////////////////////////////////////////////////////////

    // priority loop, stops at the first bit that differs from the lead bit
    always_comb begin
        logic runDone;
        runDone   = 1'b0;
        runLength = '0;
        for (int i = N - 2; i >= 0; i--) begin
            if (!runDone && (body[i] == body[N-2])) begin
                runLength = runLength + 1'b1;
            end else begin
                runDone = 1'b1;
            end
        end
    end

    // ones give k = run - 1, zeros give k = -run
    assign regimeK = body[N-2] ? $signed(runLength - 1'b1) : -$signed(runLength);

    // drop regime plus terminator, short words shift in zeros
    assign tail = body << (runLength + 1'b1);

    ///////////////////////////////////////////////////////////////////////
    // exponent and fraction
    ///////////////////////////////////////////////////////////////////////

    assign expWide  = tail[N-2 -: EB];   // top bits, only ES of them are real
    assign fracBits = tail << ES;        // missing bits read as zero

    always_comb begin
        fields          = '0;
        fields.nar      = (posit == {1'b1, {(N-1){1'b0}}});
        fields.zero     = (posit == '0);
        fields.sign     = posit[N-1];
        fields.regime   = regimeK;
        fields.exponent = expWide >> (EB - ES);   // right align the es bits
        // hidden one on top of the used width
        fields.mantissa = MB'({1'b1, fracBits});
    end

endmodule

`default_nettype wire

// File: hw/positPkg.sv
`default_nettype none
// posit divider shared definitions
// format selection, per-format widths and the packed structs that
// travel from decode to divide to encode

package positPkg;

    // supported formats, es grows with the width
    typedef enum logic [1:0] {
        posit8  = 2'd0,    // es 0
        posit16 = 2'd1,    // es 1
        posit32 = 2'd2     // es 2
    } positFormat;

    localparam int unsigned maxN      = 32;
    localparam int unsigned maxEs     = 2;
    localparam int unsigned maxRs     = 5;                   // log2 of maxN
    localparam int unsigned scaleBits = maxRs + maxEs + 5;   // signed total scale
    localparam int unsigned runBits   = maxRs + 5;           // regime run length

    // N for a format
    function automatic int unsigned positWidth(positFormat fmt);
        case (fmt)
            posit8:  return 8;
            posit32: return 32;
            default: return 16;
        endcase
    endfunction

    // ES for a format
    function automatic int unsigned expBits(positFormat fmt);
        case (fmt)
            posit8:  return 0;
            posit32: return 2;
            default: return 1;
        endcase
    endfunction

    ///////////////////////////////////////////////////////////////////////
    // stage structs, only the low bits of a field are used by small formats
    ///////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                    nar;
        logic                    zero;
        logic                    sign;
        logic signed [maxRs:0]   regime;     // signed regime count k
        logic [maxEs-1:0]        exponent;
        logic [maxN-1:0]         mantissa;   // hidden one at bit N-1
    } decodedPosit;

    typedef struct packed {
        logic                        valid;
        logic                        nar;
        logic                        zero;
        logic                        sign;
        logic signed [scaleBits-1:0] totalScale;  // k * 2^es + e
        logic [runBits-1:0]          regimeRun;   // identical regime bits
        logic [maxEs-1:0]            exponent;
        logic [2*maxN-1:0]           mantissa;    // hidden one at 2N-1, sticky at 0
    } quotientFields;

endpackage

`default_nettype wire
